/* branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_unit
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
#(
    parameter int BLOCK_W = 8
) (
    input  ex_kind_e kind,
    input  func3_t   func3,
    input  xlen_t    data1,
    input  xlen_t    data2,
    input  xlen_t    imm,
    input  pc_t      pc,
    output logic     taken,
    output pc_t      target,
    output xlen_t    link,
    output xlen_t    auipc_sum
);

    xlen_t upper_imm;
    xlen_t pc_b;
    xlen_t pc_sum;
    xlen_t jalr_sum;
    pc_t   pc_plus4;
    logic  cond;

    assign upper_imm = {{32{imm[19]}}, imm[19:0], 12'b0};
    assign pc_b      = (kind == KIND_AUIPC) ? upper_imm : imm;

    // pc relative sum, shared by branches, JAL and AUIPC
    cla_adder #(
        .BLOCK_W (BLOCK_W)
    ) pc_adder_i (
        .a   ({{(XLEN-PC_W){1'b0}}, pc}),
        .b   (pc_b),
        .cin (1'b0),
        .sum (pc_sum)
    );

    cla_adder #(
        .BLOCK_W (BLOCK_W)
    ) reg_adder_i (
        .a   (data1),
        .b   (imm),
        .cin (1'b0),
        .sum (jalr_sum)
    );

    assign pc_plus4  = pc + PC_W'(4);
    assign link      = {{(XLEN-PC_W){1'b0}}, pc_plus4};
    assign auipc_sum = pc_sum;

    always_comb begin
        case (func3)
            F3_BEQ:  cond = (data1 == data2);
            F3_BNE:  cond = (data1 != data2);
            F3_BLT:  cond = ($signed(data1) < $signed(data2));
            F3_BGE:  cond = ($signed(data1) >= $signed(data2));
            F3_BLTU: cond = (data1 < data2);
            F3_BGEU: cond = (data1 >= data2);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (kind)
            KIND_BRANCH: begin
                taken  = cond;
                target = cond ? pc_sum[PC_W-1:0] : pc_plus4;
            end
            KIND_JAL: begin
                taken  = 1'b1;
                target = pc_sum[PC_W-1:0];
            end
            KIND_JALR: begin
                taken  = 1'b1;
                target = jalr_sum[PC_W-1:0];
            end
            default: begin
                taken  = 1'b0;
                target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* cla_adder.sv */
`timescale 1ns/100ps
`default_nettype none

module cla_adder
    import ex_types_pkg::*;
#(
    parameter int BLOCK_W = 8
) (
    input  xlen_t a,
    input  xlen_t b,
    input  logic  cin,
    output xlen_t sum
);

    localparam int NBLK = XLEN / BLOCK_W;

    // Carry into each block
    logic [NBLK-1:0] blk_cin;

    assign blk_cin[0] = cin;

    for (genvar blk = 0; blk < NBLK; blk++) begin : g_blk
        logic [BLOCK_W-1:0] g;
        logic [BLOCK_W-1:0] p;
        logic [BLOCK_W-1:0] c;

        assign g = a[blk*BLOCK_W +: BLOCK_W] & b[blk*BLOCK_W +: BLOCK_W];
        assign p = a[blk*BLOCK_W +: BLOCK_W] ^ b[blk*BLOCK_W +: BLOCK_W];

        // Each carry expanded over all lower bits of the block
        always_comb begin
            logic carry;
            logic prop;
            for (int i = 0; i < BLOCK_W; i++) begin
                carry = 1'b0;
                prop  = 1'b1;
                for (int j = i - 1; j >= 0; j--) begin
                    carry = carry | (prop & g[j]);
                    prop  = prop & p[j];
                end
                c[i] = carry | (prop & blk_cin[blk]);
            end
        end

        assign sum[blk*BLOCK_W +: BLOCK_W] = p ^ c;

        if (blk < NBLK - 1) begin : g_ripple
            assign blk_cin[blk+1] = g[BLOCK_W-1] | (p[BLOCK_W-1] & c[BLOCK_W-1]);
        end
    end

endmodule

`default_nettype wire

/* ex_isa_pkg.sv */
`default_nettype none

package ex_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;

    // Arithmetic func3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch func3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_SD  = 3'b011;

    // func7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_AUIPC
    } ex_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        OPB_REG,
        OPB_IMM,
        OPB_UPPER
    } opb_sel_e;

endpackage

`default_nettype wire

/* ex_result_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_result_reg
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    output logic     out_valid,
    input  logic     out_ready,
    input  ex_kind_e kind,
    input  xlen_t    alu_result,
    input  logic     taken,
    input  pc_t      target,
    input  xlen_t    link,
    input  xlen_t    auipc_sum,
    output xlen_t    result,
    output logic     is_branch,
    output pc_t      pc_branch,
    output logic     is_load,
    output logic     mem_rw
);

    logic  accept;
    xlen_t nxt_result;
    logic  nxt_is_branch;
    pc_t   nxt_pc_branch;
    logic  nxt_is_load;
    logic  nxt_mem_rw;

    // Slot frees up in the same cycle the held result leaves
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        nxt_result    = '0;
        nxt_is_branch = 1'b0;
        nxt_pc_branch = '0;
        nxt_is_load   = 1'b0;
        nxt_mem_rw    = 1'b0;
        case (kind)
            KIND_ALU: nxt_result = alu_result;
            KIND_LOAD: begin
                nxt_result  = alu_result;
                nxt_is_load = 1'b1;
            end
            KIND_STORE: begin
                nxt_result = alu_result;
                nxt_mem_rw = 1'b1;
            end
            KIND_BRANCH: begin
                nxt_is_branch = taken;
                nxt_pc_branch = target;
            end
            KIND_JAL,
            KIND_JALR: begin
                nxt_result    = link;
                nxt_is_branch = taken;
                nxt_pc_branch = target;
            end
            KIND_AUIPC: nxt_result = auipc_sum;
            default: nxt_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            is_branch <= 1'b0;
            pc_branch <= '0;
            is_load   <= 1'b0;
            mem_rw    <= 1'b0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (accept) begin
                result    <= nxt_result;
                is_branch <= nxt_is_branch;
                pc_branch <= nxt_pc_branch;
                is_load   <= nxt_is_load;
                mem_rw    <= nxt_mem_rw;
            end
        end
    end

endmodule

`default_nettype wire

/* ex_stage.f */
ex_types_pkg.sv
ex_isa_pkg.sv
op_decoder.sv
cla_adder.sv
int_alu.sv
branch_unit.sv
ex_result_reg.sv
ex_stage.sv
tb_ex_stage.sv

/* ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
#(
    parameter int BLOCK_W = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  opcode_t opcode,
    input  func3_t  func3,
    input  func7_t  func7,
    input  xlen_t   imm,
    input  xlen_t   data1,
    input  xlen_t   data2,
    input  pc_t     pc,
    output logic    out_valid,
    input  logic    out_ready,
    output xlen_t   result,
    output logic    is_branch,
    output pc_t     pc_branch,
    output logic    is_load,
    output logic    mem_rw
);

    ex_kind_e kind;
    alu_op_e  alu_op;
    opb_sel_e opb_sel;
    logic     word_op;
    xlen_t    alu_result;
    logic     taken;
    pc_t      target;
    xlen_t    link;
    xlen_t    auipc_sum;

    op_decoder decoder_i (
        .opcode  (opcode),
        .func3   (func3),
        .func7   (func7),
        .kind    (kind),
        .alu_op  (alu_op),
        .opb_sel (opb_sel),
        .word_op (word_op)
    );

    int_alu #(
        .BLOCK_W (BLOCK_W)
    ) alu_i (
        .data1      (data1),
        .data2      (data2),
        .imm        (imm),
        .alu_op     (alu_op),
        .opb_sel    (opb_sel),
        .word_op    (word_op),
        .alu_result (alu_result)
    );

    branch_unit #(
        .BLOCK_W (BLOCK_W)
    ) branch_i (
        .kind      (kind),
        .func3     (func3),
        .data1     (data1),
        .data2     (data2),
        .imm       (imm),
        .pc        (pc),
        .taken     (taken),
        .target    (target),
        .link      (link),
        .auipc_sum (auipc_sum)
    );

    // Single output register stage with the handshake
    ex_result_reg result_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .kind       (kind),
        .alu_result (alu_result),
        .taken      (taken),
        .target     (target),
        .link       (link),
        .auipc_sum  (auipc_sum),
        .result     (result),
        .is_branch  (is_branch),
        .pc_branch  (pc_branch),
        .is_load    (is_load),
        .mem_rw     (mem_rw)
    );

endmodule

`default_nettype wire

/* ex_stage_golden.hex */
// opcode func3 func7 imm data1 data2 pc | result is_branch pc_branch is_load mem_rw
// all fields in hex, one instruction per line
33 0 00 0000000000000000 0000000000000005 0000000000000003 00001000 0000000000000008 0 00000000 0 0
33 0 20 0000000000000000 0000000000000003 0000000000000005 00001000 fffffffffffffffe 0 00000000 0 0
33 1 00 0000000000000000 0000000000000001 0000000000000044 00001000 0000000000000010 0 00000000 0 0
33 2 00 0000000000000000 ffffffffffffffff 0000000000000001 00001000 0000000000000001 0 00000000 0 0
33 3 00 0000000000000000 ffffffffffffffff 0000000000000001 00001000 0000000000000000 0 00000000 0 0
33 4 00 0000000000000000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 00001000 0ff00ff00ff00ff0 0 00000000 0 0
33 5 00 0000000000000000 8000000000000000 000000000000003c 00001000 0000000000000008 0 00000000 0 0
33 5 20 0000000000000000 8000000000000000 000000000000003c 00001000 fffffffffffffff8 0 00000000 0 0
33 6 00 0000000000000000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 00001000 0fff0fff0fff0fff 0 00000000 0 0
33 7 00 0000000000000000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 00001000 000f000f000f000f 0 00000000 0 0
13 0 00 fffffffffffffff0 0000000000000100 0000000000000000 00001000 00000000000000f0 0 00000000 0 0
13 2 00 0000000000000005 fffffffffffffffb 0000000000000000 00001000 0000000000000001 0 00000000 0 0
13 3 00 fffffffffffffffb 0000000000000005 0000000000000000 00001000 0000000000000001 0 00000000 0 0
13 4 00 ffffffffffffffff 0000000012345678 0000000000000000 00001000 ffffffffedcba987 0 00000000 0 0
13 6 00 00000000000000f0 000000000000000f 0000000000000000 00001000 00000000000000ff 0 00000000 0 0
13 7 00 00000000000000f0 00000000000000ff 0000000000000000 00001000 00000000000000f0 0 00000000 0 0
13 1 00 0000000000000020 0000000000000001 0000000000000000 00001000 0000000100000000 0 00000000 0 0
13 5 01 0000000000000021 ffffffff00000000 0000000000000000 00001000 000000007fffffff 0 00000000 0 0
13 5 20 0000000000000404 fffffffffffff000 0000000000000000 00001000 ffffffffffffff00 0 00000000 0 0
3b 0 00 0000000000000000 000000007fffffff 0000000000000001 00001000 ffffffff80000000 0 00000000 0 0
3b 0 20 0000000000000000 1234567800000005 0000000000000007 00001000 fffffffffffffffe 0 00000000 0 0
3b 1 00 0000000000000000 0000000000000003 000000000000003f 00001000 ffffffff80000000 0 00000000 0 0
3b 5 00 0000000000000000 ffffffff80000000 0000000000000004 00001000 0000000008000000 0 00000000 0 0
3b 5 20 0000000000000000 0000000080000000 0000000000000004 00001000 fffffffff8000000 0 00000000 0 0
1b 1 00 0000000000000004 00000000f0000001 0000000000000000 00001000 0000000000000010 0 00000000 0 0
1b 0 00 ffffffffffffffff 0000000100000000 0000000000000000 00001000 ffffffffffffffff 0 00000000 0 0
03 3 00 0000000000000010 0000000080001000 0000000000000000 00001000 0000000080001010 0 00000000 1 0
23 2 00 fffffffffffffff8 0000000000002000 00000000deadbeef 00001000 0000000000001ff8 0 00000000 0 1
03 7 00 0000000000000010 0000000000000100 0000000000000000 00001000 0000000000000000 0 00000000 0 0
7f 0 00 0000000000000000 0000000000000005 0000000000000003 00001000 0000000000000000 0 00000000 0 0
63 0 00 0000000000000020 0000000000000005 0000000000000005 00001000 0000000000000000 1 00001020 0 0
63 0 00 0000000000000020 0000000000000005 0000000000000006 00001000 0000000000000000 0 00001004 0 0
63 1 00 fffffffffffffff0 0000000000000005 0000000000000006 00002000 0000000000000000 1 00001ff0 0 0
63 1 00 0000000000000020 0000000000000005 0000000000000005 00001000 0000000000000000 0 00001004 0 0
63 4 00 0000000000000020 ffffffffffffffff 0000000000000001 00001000 0000000000000000 1 00001020 0 0
63 4 00 0000000000000020 0000000000000001 ffffffffffffffff 00001000 0000000000000000 0 00001004 0 0
63 5 00 0000000000000020 0000000000000001 ffffffffffffffff 00001000 0000000000000000 1 00001020 0 0
63 5 00 0000000000000020 ffffffffffffffff 0000000000000001 00001000 0000000000000000 0 00001004 0 0
63 6 00 0000000000000020 0000000000000001 ffffffffffffffff 00001000 0000000000000000 1 00001020 0 0
63 6 00 0000000000000020 ffffffffffffffff 0000000000000001 00001000 0000000000000000 0 00001004 0 0
63 7 00 0000000000000020 ffffffffffffffff 0000000000000001 00001000 0000000000000000 1 00001020 0 0
63 7 00 0000000000000020 0000000000000001 ffffffffffffffff 00001000 0000000000000000 0 00001004 0 0
6f 0 00 0000000000000100 0000000000000000 0000000000000000 00004000 0000000000004004 1 00004100 0 0
67 0 00 0000000000000008 0000000000003000 0000000000000000 00005000 0000000000005004 1 00003008 0 0
17 0 00 0000000000080000 0000000000000000 0000000000000000 00001000 ffffffff80001000 0 00000000 0 0
17 0 00 0000000000012345 0000000000000000 0000000000000000 00001000 0000000012346000 0 00000000 0 0
37 0 00 00000000000abcde 0000000000000000 0000000000000000 00001000 ffffffffabcde000 0 00000000 0 0

/* ex_types_pkg.sv */
`default_nettype none

package ex_types_pkg;

    // Integer datapath width
    localparam int XLEN = 64;

    // Instruction address width
    localparam int PC_W = 32;

    // Register operand, immediate or result word
    typedef logic [XLEN-1:0] xlen_t;

    // Instruction address
    typedef logic [PC_W-1:0] pc_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] func3_t;
    typedef logic [6:0] func7_t;

endpackage

`default_nettype wire

/* int_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module int_alu
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
#(
    parameter int BLOCK_W = 8
) (
    input  xlen_t    data1,
    input  xlen_t    data2,
    input  xlen_t    imm,
    input  alu_op_e  alu_op,
    input  opb_sel_e opb_sel,
    input  logic     word_op,
    output xlen_t    alu_result
);

    xlen_t      upper_imm;
    xlen_t      opb;
    xlen_t      add_b;
    xlen_t      sum;
    logic       sub_op;
    logic [5:0] shamt;
    xlen_t      cmp_a;
    xlen_t      cmp_b;
    xlen_t      srl_src;
    xlen_t      raw;

    // LUI and AUIPC immediate
    assign upper_imm = {{32{imm[19]}}, imm[19:0], 12'b0};

    always_comb begin
        case (opb_sel)
            OPB_IMM:   opb = imm;
            OPB_UPPER: opb = upper_imm;
            default:   opb = data2;
        endcase
    end

    // Subtract as a + ~b + 1
    assign sub_op = (alu_op == ALU_SUB);
    assign add_b  = sub_op ? ~opb : opb;

    cla_adder #(
        .BLOCK_W (BLOCK_W)
    ) adder_i (
        .a   (data1),
        .b   (add_b),
        .cin (sub_op),
        .sum (sum)
    );

    assign shamt = word_op ? {1'b0, opb[4:0]} : opb[5:0];

    // W forms work on the low word
    assign cmp_a   = word_op ? {{32{data1[31]}}, data1[31:0]} : data1;
    assign cmp_b   = word_op ? {{32{opb[31]}}, opb[31:0]} : opb;
    assign srl_src = word_op ? {32'b0, data1[31:0]} : data1;

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB:    raw = sum;
            ALU_SLL:    raw = data1 << shamt;
            ALU_SLT:    raw = {63'b0, $signed(cmp_a) < $signed(cmp_b)};
            ALU_SLTU:   raw = {63'b0, cmp_a < cmp_b};
            ALU_XOR:    raw = data1 ^ opb;
            ALU_SRL:    raw = srl_src >> shamt;
            ALU_SRA:    raw = $signed(cmp_a) >>> shamt;
            ALU_OR:     raw = data1 | opb;
            ALU_AND:    raw = data1 & opb;
            ALU_PASS_B: raw = opb;
            default:    raw = '0;
        endcase
    end

    assign alu_result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* op_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module op_decoder
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input  opcode_t  opcode,
    input  func3_t   func3,
    input  func7_t   func7,
    output ex_kind_e kind,
    output alu_op_e  alu_op,
    output opb_sel_e opb_sel,
    output logic     word_op
);

    // Register and immediate forms share one func3 mapping
    function automatic alu_op_e base_op(input func3_t f3);
        case (f3)
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        kind    = KIND_NONE;
        alu_op  = ALU_ADD;
        opb_sel = OPB_REG;
        word_op = 1'b0;

        case (opcode)
            OPC_OP: begin
                alu_op = base_op(func3);
                if (func7 == F7_BASE) begin
                    kind   = KIND_ALU;
                    alu_op = (func3 == F3_SRL_SRA) ? ALU_SRL : base_op(func3);
                end else if (func7 == F7_ALT &&
                             (func3 == F3_ADD_SUB || func3 == F3_SRL_SRA)) begin
                    kind   = KIND_ALU;
                    alu_op = (func3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_OP_32: begin
                word_op = 1'b1;
                if (func3 == F3_ADD_SUB || func3 == F3_SLL || func3 == F3_SRL_SRA) begin
                    if (func7 == F7_BASE) begin
                        kind   = KIND_ALU;
                        alu_op = (func3 == F3_SRL_SRA) ? ALU_SRL : base_op(func3);
                    end else if (func7 == F7_ALT && func3 != F3_SLL) begin
                        kind   = KIND_ALU;
                        alu_op = (func3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                    end
                end
            end
            OPC_OP_IMM: begin
                opb_sel = OPB_IMM;
                alu_op  = base_op(func3);
                // func7[0] is shamt bit 5 here
                if (func3 == F3_SLL) begin
                    if (func7[6:1] == F7_BASE[6:1]) begin
                        kind = KIND_ALU;
                    end
                end else if (func3 == F3_SRL_SRA) begin
                    if (func7[6:1] == F7_BASE[6:1]) begin
                        kind   = KIND_ALU;
                        alu_op = ALU_SRL;
                    end else if (func7[6:1] == F7_ALT[6:1]) begin
                        kind   = KIND_ALU;
                        alu_op = ALU_SRA;
                    end
                end else begin
                    kind = KIND_ALU;
                end
            end
            OPC_OP_IMM_32: begin
                opb_sel = OPB_IMM;
                word_op = 1'b1;
                if (func3 == F3_ADD_SUB) begin
                    kind = KIND_ALU;
                end else if (func3 == F3_SLL && func7 == F7_BASE) begin
                    kind   = KIND_ALU;
                    alu_op = ALU_SLL;
                end else if (func3 == F3_SRL_SRA && func7 == F7_BASE) begin
                    kind   = KIND_ALU;
                    alu_op = ALU_SRL;
                end else if (func3 == F3_SRL_SRA && func7 == F7_ALT) begin
                    kind   = KIND_ALU;
                    alu_op = ALU_SRA;
                end
            end
            OPC_LOAD: begin
                opb_sel = OPB_IMM;
                if (func3 <= F3_LWU) begin
                    kind = KIND_LOAD;
                end
            end
            OPC_STORE: begin
                opb_sel = OPB_IMM;
                if (func3 <= F3_SD) begin
                    kind = KIND_STORE;
                end
            end
            OPC_BRANCH: begin
                if (func3 != 3'b010 && func3 != 3'b011) begin
                    kind = KIND_BRANCH;
                end
            end
            OPC_JAL: kind = KIND_JAL;
            OPC_JALR: begin
                if (func3 == 3'b000) begin
                    kind = KIND_JALR;
                end
            end
            OPC_AUIPC: kind = KIND_AUIPC;
            OPC_LUI: begin
                kind    = KIND_ALU;
                alu_op  = ALU_PASS_B;
                opb_sel = OPB_UPPER;
            end
            default: kind = KIND_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the ex_stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ex_stage -f ex_stage.f \
    -o sim_ex_stage > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_ex_stage > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log && exit 0 || exit 1

/* tb_ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage
    import ex_types_pkg::*;
();

    typedef struct {
        opcode_t opcode;
        func3_t  func3;
        func7_t  func7;
        xlen_t   imm;
        xlen_t   data1;
        xlen_t   data2;
        pc_t     pc;
        xlen_t   result;
        logic    is_branch;
        pc_t     pc_branch;
        logic    is_load;
        logic    mem_rw;
    } vector_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    opcode_t opcode;
    func3_t  func3;
    func7_t  func7;
    xlen_t   imm;
    xlen_t   data1;
    xlen_t   data2;
    pc_t     pc;
    logic    out_valid;
    logic    out_ready;
    xlen_t   result;
    logic    is_branch;
    pc_t     pc_branch;
    logic    is_load;
    logic    mem_rw;

    vector_t     vecs[$];
    int          pending[$];
    logic [15:0] lfsr;
    int          value_errors;
    int          other_errors;

    ex_stage #(
        .BLOCK_W (8)
    ) ex_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .opcode    (opcode),
        .func3     (func3),
        .func7     (func7),
        .imm       (imm),
        .data1     (data1),
        .data2     (data2),
        .pc        (pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .is_branch (is_branch),
        .pc_branch (pc_branch),
        .is_load   (is_load),
        .mem_rw    (mem_rw)
    );

    always #5 clk = ~clk;

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        fd = $fopen("ex_stage_golden.hex", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open ex_stage_golden.hex");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comment and blank lines
            if (line.len() > 1 && line.getc(0) != "/") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            v.opcode, v.func3, v.func7, v.imm, v.data1, v.data2, v.pc,
                            v.result, v.is_branch, v.pc_branch, v.is_load, v.mem_rw);
                if (n == 12) begin
                    vecs.push_back(v);
                end else begin
                    other_errors++;
                    $display("Golden file line could not be parsed: %s", line);
                end
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            other_errors++;
            $display("Golden file holds no vectors");
        end
    endtask

    task automatic drive_vector(input vector_t v);
        opcode = v.opcode;
        func3  = v.func3;
        func7  = v.func7;
        imm    = v.imm;
        data1  = v.data1;
        data2  = v.data2;
        pc     = v.pc;
    endtask

    task automatic check_outputs(input int i);
        vector_t v;
        v = vecs[i];
        check_data($sformatf("vector %0d result", i), result, v.result);
        check_flag($sformatf("vector %0d is_branch", i), is_branch, v.is_branch);
        check_pc($sformatf("vector %0d pc_branch", i), pc_branch, v.pc_branch);
        check_flag($sformatf("vector %0d is_load", i), is_load, v.is_load);
        check_flag($sformatf("vector %0d mem_rw", i), mem_rw, v.mem_rw);
    endtask

    initial begin
        int    idx;
        int    cycles;
        int    limit;
        int    last_vec;
        logic  gap;
        logic  drop;
        logic  fed_last;
        logic  holding;
        xlen_t held_result;
        logic  held_branch;
        pc_t   held_pc_branch;
        logic  held_load;
        logic  held_rw;

        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        opcode       = '0;
        func3        = '0;
        func7        = '0;
        imm          = '0;
        data1        = '0;
        data2        = '0;
        pc           = '0;
        value_errors = 0;
        other_errors = 0;
        lfsr         = 16'd13246;
        idx          = 0;
        cycles       = 0;
        last_vec     = 0;
        fed_last     = 1'b0;
        holding      = 1'b0;

        load_vectors();
        limit = 8 * vecs.size() + 50;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_flag("reset out_valid", out_valid, 1'b0);
        check_flag("reset in_ready", in_ready, 1'b1);
        check_data("reset result", result, '0);
        check_flag("reset is_branch", is_branch, 1'b0);
        check_pc("reset pc_branch", pc_branch, '0);
        check_flag("reset is_load", is_load, 1'b0);
        check_flag("reset mem_rw", mem_rw, 1'b0);

        while ((idx < vecs.size() || pending.size() > 0) && cycles < limit) begin
            @(negedge clk);
            cycles++;
            // Fields only change once the held instruction is taken
            if (!in_valid || fed_last) begin
                take_bit(gap);
                if (idx < vecs.size() && !gap) begin
                    drive_vector(vecs[idx]);
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            take_bit(drop);
            out_ready = !drop;
            #1;

            if (fed_last) begin
                check_flag($sformatf("vector %0d out_valid latency", last_vec), out_valid, 1'b1);
            end
            if (holding && pending.size() > 0) begin
                check_data($sformatf("vector %0d held result", pending[0]),
                           result, held_result);
                check_flag($sformatf("vector %0d held is_branch", pending[0]),
                           is_branch, held_branch);
                check_pc($sformatf("vector %0d held pc_branch", pending[0]),
                         pc_branch, held_pc_branch);
                check_flag($sformatf("vector %0d held is_load", pending[0]),
                           is_load, held_load);
                check_flag($sformatf("vector %0d held mem_rw", pending[0]),
                           mem_rw, held_rw);
            end
            check_flag("in_ready", in_ready, !out_valid || out_ready);

            holding        = out_valid && !out_ready;
            held_result    = result;
            held_branch    = is_branch;
            held_pc_branch = pc_branch;
            held_load      = is_load;
            held_rw        = mem_rw;

            if (out_valid && pending.size() == 0) begin
                other_errors++;
                $display("Output valid at cycle %0d with no instruction outstanding", cycles);
            end else if (out_valid && out_ready) begin
                check_outputs(pending.pop_front());
            end

            fed_last = in_valid && in_ready;
            if (fed_last) begin
                pending.push_back(idx);
                last_vec = idx;
                idx++;
            end
        end

        if (idx < vecs.size() || pending.size() > 0) begin
            other_errors++;
            $display("Timeout after %0d cycles: %0d of %0d vectors sent, %0d results missing",
                     cycles, idx, vecs.size(), pending.size());
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
